/* files.f */
verilog/cache_pkg.sv
verilog/cache_way.sv
verilog/cache_hit_resolve.sv
verilog/cache_ctrl.sv
verilog/cache.sv
test/cache_checker.sv
test/tb_cache.sv

/* test/tb_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

  localparam logic [31:0] seed     = 32'd93;
  // every memory word starts as its byte address XORed with this key
  localparam logic [31:0] fill_key = 32'h5a3c_96e1;
  localparam int n_reset = 16;
  localparam int n_hit   = 40;
  localparam int n_fill  = 60;
  localparam int n_write = 60;
  localparam int n_repl  = 24;
  localparam int n_ops   = n_reset + n_hit + n_fill + n_write + n_repl;
  // memory ready and valid delays of 0 to 3 cycles
  localparam int delay_bits   = 2;
  localparam int worst_cycles = 40;
  localparam int clk_period   = 8;
  localparam logic [4:0] repl_set = 5'd9;

  logic        clk;
  logic        rst;
  logic        mem_ready;
  logic [31:0] mem_rdata;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic        mem_ren;
  logic        mem_wen;
  logic [31:0] mem_wdata;
  logic [31:0] req_addr;
  logic        req_ren;
  logic        req_wen;
  logic [3:0]  req_mask;
  logic [31:0] req_wdata;
  logic        busy;
  logic [31:0] res_rdata;
  logic [2:0]  test_id;
  logic        test_done;
  logic [31:0] checks;
  logic [31:0] errors;
  // separate generators so the stimulus and memory processes never share one
  logic [31:0] stim_lfsr;
  logic [31:0] mem_lfsr;
  // word memory covering tags 0 to 3, which is the first 2 KiB
  logic [31:0] mem [512];
  int          mem_phase;
  int          mem_cnt;
  logic [8:0]  rd_word;

  cache i_dut (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_mem_ready (mem_ready),
    .i_mem_rdata (mem_rdata),
    .i_mem_valid (mem_valid),
    .o_mem_addr  (mem_addr),
    .o_mem_ren   (mem_ren),
    .o_mem_wen   (mem_wen),
    .o_mem_wdata (mem_wdata),
    .i_req_addr  (req_addr),
    .i_req_ren   (req_ren),
    .i_req_wen   (req_wen),
    .i_req_mask  (req_mask),
    .i_req_wdata (req_wdata),
    .o_busy      (busy),
    .o_res_rdata (res_rdata)
  );

  cache_checker #(.fill_key(fill_key)) u_checker (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_test      (test_id),
    .i_test_done (test_done),
    .i_req_addr  (req_addr),
    .i_req_ren   (req_ren),
    .i_req_wen   (req_wen),
    .i_req_mask  (req_mask),
    .i_req_wdata (req_wdata),
    .i_busy      (busy),
    .i_res_rdata (res_rdata),
    .i_mem_addr  (mem_addr),
    .i_mem_ren   (mem_ren),
    .i_mem_wen   (mem_wen),
    .i_mem_wdata (mem_wdata),
    .o_checks    (checks),
    .o_errors    (errors)
  );

  // right-shifting Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // one step for each bit taken, the first bit taken ends up as the msb of the value
  task automatic draw(inout logic [31:0] state, input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], state[0]};
      state = lfsr_step(state);
    end
  endtask

  // the four sets that the random phases spread over
  function automatic logic [4:0] set_of(input logic [1:0] s);
    case (s)
      2'd0: return 5'd1;
      2'd1: return 5'd6;
      2'd2: return 5'd19;
      default: return 5'd30;
    endcase
  endfunction

  function automatic logic [31:0] make_addr(input logic [1:0] tag, input logic [4:0] set,
                                            input logic [1:0] word);
    return {21'b0, tag, set, word, 2'b00};
  endfunction

  // one request, held until the cache drops o_busy
  task automatic do_req(input logic wr, input logic [31:0] addr, input logic [3:0] mask,
                        input logic [31:0] wdata);
    logic stall;
    @(negedge clk);
    req_addr  = addr;
    req_mask  = mask;
    req_wdata = wdata;
    req_ren   = !wr;
    req_wen   = wr;
    @(negedge clk);
    // sample before the strobe drops so a hit still reads as not busy
    stall   = busy;
    req_ren = 1'b0;
    req_wen = 1'b0;
    while (stall) begin
      @(negedge clk);
      stall = busy;
    end
  endtask

  task automatic run_phase(input int n, input int tag_span, input logic use_store,
                           input logic one_set);
    logic [31:0] v;
    logic [1:0]  tag;
    logic [4:0]  set;
    logic [1:0]  word;
    logic [3:0]  mask;
    logic        wr;
    logic [31:0] wdata;
    for (int k = 0; k < n; k++) begin
      draw(stim_lfsr, 2, v);
      tag = 2'(v % tag_span);
      set = repl_set;
      if (!one_set) begin
        draw(stim_lfsr, 2, v);
        set = set_of(v[1:0]);
      end
      draw(stim_lfsr, 2, v);
      word = v[1:0];
      draw(stim_lfsr, 4, v);
      mask = v[3:0];
      wr = 1'b0;
      wdata = '0;
      if (use_store) begin
        draw(stim_lfsr, 1, v);
        wr = v[0];
      end
      if (wr) begin
        draw(stim_lfsr, 32, wdata);
      end
      do_req(wr, make_addr(tag, set, word), mask, wdata);
    end
  endtask

  // the checker prints the result line of the test on this pulse
  task automatic end_test;
    @(negedge clk);
    test_done = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // memory: a strobe drops ready, a read answers with one valid pulse,
  // then ready comes back, each wait 0 to 3 cycles
  initial begin
    logic [31:0] v;
    mem_lfsr  = seed;
    mem_ready = 1'b1;
    mem_valid = 1'b0;
    mem_rdata = '0;
    mem_phase = 0;
    mem_cnt   = 0;
    rd_word   = '0;
    for (int i = 0; i < 512; i++) begin
      mem[i] = {21'b0, 9'(i), 2'b00} ^ fill_key;
    end
    forever begin
      @(negedge clk);
      mem_valid = 1'b0;
      case (mem_phase)
        0: begin
          if (mem_ren) begin
            mem_ready = 1'b0;
            rd_word   = mem_addr[10:2];
            draw(mem_lfsr, delay_bits, v);
            mem_cnt   = v;
            mem_phase = 1;
          end else if (mem_wen) begin
            mem[mem_addr[10:2]] = mem_wdata;
            mem_ready = 1'b0;
            draw(mem_lfsr, delay_bits, v);
            mem_cnt   = v;
            mem_phase = 2;
          end
        end
        1: begin
          if (mem_cnt == 0) begin
            mem_valid = 1'b1;
            mem_rdata = mem[rd_word];
            draw(mem_lfsr, delay_bits, v);
            mem_cnt   = v;
            mem_phase = 2;
          end else begin
            mem_cnt = mem_cnt - 1;
          end
        end
        default: begin
          if (mem_cnt == 0) begin
            mem_ready = 1'b1;
            mem_phase = 0;
          end else begin
            mem_cnt = mem_cnt - 1;
          end
        end
      endcase
    end
  end

  initial begin
    #((n_ops * worst_cycles + 20) * clk_period);
    $display("timeout: the cache did not finish the requests in time");
    $display("test failed");
    $finish;
  end

  initial begin
    stim_lfsr = seed;
    rst       = 1'b1;
    req_addr  = '0;
    req_ren   = 1'b0;
    req_wen   = 1'b0;
    req_mask  = '0;
    req_wdata = '0;
    test_id   = 3'd0;
    test_done = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // every line of the pool read once from an empty cache
    for (int t = 0; t < 4; t++) begin
      for (int s = 0; s < 4; s++) begin
        do_req(1'b0, make_addr(2'(t), set_of(2'(s)), 2'd0), 4'hf, 32'h0);
      end
    end
    end_test();
    // two tags fit both ways, so these settle into hits
    test_id = 3'd1;
    run_phase(n_hit, 2, 1'b0, 1'b0);
    end_test();
    test_id = 3'd2;
    run_phase(n_fill, 4, 1'b0, 1'b0);
    end_test();
    test_id = 3'd3;
    run_phase(n_write, 4, 1'b1, 1'b0);
    end_test();
    // three tags fight over the two ways of one set
    test_id = 3'd4;
    run_phase(n_repl, 3, 1'b1, 1'b1);
    end_test();
    @(negedge clk);
    $display("totals: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/cache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_checker #(
  parameter logic [31:0] fill_key = 32'h0
) (
  input  wire        i_clk,
  input  wire        i_rst,
  // test index and end-of-test pulse from the stimulus
  input  wire [2:0]  i_test,
  input  wire        i_test_done,
  input  wire [31:0] i_req_addr,
  input  wire        i_req_ren,
  input  wire        i_req_wen,
  input  wire [3:0]  i_req_mask,
  input  wire [31:0] i_req_wdata,
  input  wire        i_busy,
  input  wire [31:0] i_res_rdata,
  input  wire [31:0] i_mem_addr,
  input  wire        i_mem_ren,
  input  wire        i_mem_wen,
  input  wire [31:0] i_mem_wdata,
  output wire [31:0] o_checks,
  output wire [31:0] o_errors
);

  // reference words of the 2 KiB window, updated by every store
  logic [31:0] ref_mem [512];
  // valid bits, tags and MRU way of each set as the cache should hold them
  logic [1:0]  valid_m [32];
  logic [22:0] tag_m   [32][2];
  logic        mru_m   [32];
  // the request in flight
  logic        active;
  logic        act_read;
  logic        act_miss;
  logic [31:0] act_addr;
  logic [3:0]  act_mask;
  logic [31:0] act_merged;
  int          ren_seen;
  int          wen_seen;
  logic        rst_q;
  int          checks;
  int          errors;
  int          test_checks;
  int          test_errors;

  assign o_checks = checks;
  assign o_errors = errors;

  initial begin
    for (int i = 0; i < 512; i++) begin
      ref_mem[i] = {21'b0, 9'(i), 2'b00} ^ fill_key;
    end
    active      = 1'b0;
    rst_q       = 1'b0;
    checks      = 0;
    errors      = 0;
    test_checks = 0;
    test_errors = 0;
  end

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0: return "reset";
      3'd1: return "read_hit";
      3'd2: return "line_fill";
      3'd3: return "write_through";
      default: return "replacement";
    endcase
  endfunction

  // bytes outside the mask become zero
  function automatic logic [31:0] mask_word(input logic [31:0] w, input logic [3:0] m);
    logic [31:0] r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = m[b] ? w[8*b +: 8] : 8'h00;
    end
    return r;
  endfunction

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    test_checks++;
    if (exp !== act) begin
      errors++;
      test_errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", test_name(i_test), what, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    test_errors++;
    $display("ERROR in %s: %s", test_name(i_test), msg);
  endtask

  // predict hit or miss, update the model and open the request
  task automatic start_request;
    logic [4:0]  set;
    logic [22:0] tag;
    logic [1:0]  hits;
    logic        way;
    logic        miss;
    logic        exp_busy;
    logic [8:0]  widx;
    set  = i_req_addr[8:4];
    tag  = i_req_addr[31:9];
    widx = i_req_addr[10:2];
    hits[0] = valid_m[set][0] && (tag_m[set][0] == tag);
    hits[1] = valid_m[set][1] && (tag_m[set][1] == tag);
    miss = !(|hits);
    way  = hits[1];
    exp_busy = i_req_wen || miss;
    check_word("o_busy in request cycle", {31'b0, exp_busy}, {31'b0, i_busy});
    // empty ways first, lowest first, then the way that is not MRU
    if (miss) begin
      way = !valid_m[set][0] ? 1'b0 : (!valid_m[set][1] ? 1'b1 : !mru_m[set]);
      valid_m[set][way] = 1'b1;
      tag_m[set][way]   = tag;
      mru_m[set]        = way;
    end
    if (i_req_wen) begin
      act_merged    = mask_word(i_req_wdata, i_req_mask) | mask_word(ref_mem[widx], ~i_req_mask);
      ref_mem[widx] = act_merged;
      mru_m[set]    = way;
    end
    if (!exp_busy) begin
      check_word("read hit data", mask_word(ref_mem[widx], i_req_mask), i_res_rdata);
    end
    active   = i_busy;
    act_read = i_req_ren;
    act_miss = miss;
    act_addr = i_req_addr;
    act_mask = i_req_mask;
    ren_seen = 0;
    wen_seen = 0;
  endtask

  always @(posedge i_clk) begin
    if (i_rst) begin
      for (int s = 0; s < 32; s++) begin
        valid_m[s] = 2'b00;
        mru_m[s]   = 1'b0;
      end
      active = 1'b0;
    end else begin
      // first edge out of reset, before any request
      if (rst_q) begin
        check_word("o_busy after reset", 32'h0, {31'b0, i_busy});
        check_word("o_mem_ren after reset", 32'h0, {31'b0, i_mem_ren});
        check_word("o_mem_wen after reset", 32'h0, {31'b0, i_mem_wen});
      end
      if (active) begin
        if (i_mem_ren) begin
          if (!act_miss || ren_seen >= 4) begin
            report_error("line read outside a miss or after the fourth word");
          end else begin
            check_word("fill address", {act_addr[31:4], 2'(ren_seen), 2'b00}, i_mem_addr);
          end
          ren_seen++;
        end
        if (i_mem_wen) begin
          if (act_read || wen_seen > 0) begin
            report_error("memory write that no store asked for");
          end else begin
            check_word("write address", {act_addr[31:2], 2'b00}, i_mem_addr);
            check_word("write data", act_merged, i_mem_wdata);
          end
          wen_seen++;
        end
        // o_busy has dropped, so the request is complete
        if (!i_busy) begin
          if (ren_seen != (act_miss ? 4 : 0)) begin
            report_error("wrong number of line reads for the request");
          end
          if (!act_read && wen_seen == 0) begin
            report_error("store finished without a memory write");
          end
          if (act_read) begin
            check_word("read data after fill",
                       mask_word(ref_mem[act_addr[10:2]], act_mask), i_res_rdata);
          end
          active = 1'b0;
        end
      end else begin
        if (i_mem_ren || i_mem_wen) begin
          report_error("memory strobe while no request is in flight");
        end
        if (i_req_ren || i_req_wen) begin
          start_request();
        end
      end
      if (i_test_done) begin
        $display("%s: %0d checks, %0d errors", test_name(i_test), test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
      end
    end
    rst_q = i_rst;
  end

endmodule

`default_nettype wire

/* verilog/cache.sv */
`timescale 1ns/1ps
`default_nettype none

module cache
  import cache_pkg::*;
(
  input  wire         i_clk,
  input  wire         i_rst,
  // word memory port
  input  wire         i_mem_ready,
  input  wire  [31:0] i_mem_rdata,
  input  wire         i_mem_valid,
  output logic [31:0] o_mem_addr,
  output logic        o_mem_ren,
  output logic        o_mem_wen,
  output logic [31:0] o_mem_wdata,
  // CPU port
  input  wire  [31:0] i_req_addr,
  input  wire         i_req_ren,
  input  wire         i_req_wen,
  input  wire  [3:0]  i_req_mask,
  input  wire  [31:0] i_req_wdata,
  output logic        o_busy,
  output logic [31:0] o_res_rdata
);

  // the request address seen through its field view
  cache_addr_t               req_addr;
  logic [num_ways-1:0]       way_wr;
  logic [num_ways-1:0]       tag_wr;
  logic [num_ways-1:0]       way_hit;
  logic [num_ways-1:0]       way_valid;
  logic [num_ways-1:0][31:0] way_rdata;
  logic [word_sel_bits-1:0]  fill_word;
  logic [31:0]               line_wdata;
  logic [31:0]               hit_rdata;
  logic                      hit;
  logic                      hit_way;
  logic                      victim;
  logic                      set_mru_en;
  logic                      set_mru;

  assign req_addr = i_req_addr;

  cache_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_req_ren    (i_req_ren),
    .i_req_wen    (i_req_wen),
    .i_req_addr   (req_addr),
    .i_req_mask   (i_req_mask),
    .i_req_wdata  (i_req_wdata),
    .i_hit        (hit),
    .i_hit_way    (hit_way),
    .i_hit_rdata  (hit_rdata),
    .i_victim     (victim),
    .i_mem_ready  (i_mem_ready),
    .i_mem_valid  (i_mem_valid),
    .i_mem_rdata  (i_mem_rdata),
    .o_busy       (o_busy),
    .o_mem_addr   (o_mem_addr),
    .o_mem_ren    (o_mem_ren),
    .o_mem_wen    (o_mem_wen),
    .o_mem_wdata  (o_mem_wdata),
    .o_way_wr     (way_wr),
    .o_tag_wr     (tag_wr),
    .o_fill_word  (fill_word),
    .o_line_wdata (line_wdata),
    .o_set_mru_en (set_mru_en),
    .o_set_mru    (set_mru)
  );

  // every way shares the address and write data, only the strobes differ
  for (genvar w = 0; w < num_ways; w++) begin : g_way
    cache_way u_way (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_addr    (req_addr),
      .i_wr      (way_wr[w]),
      .i_tag_wr  (tag_wr[w]),
      .i_wr_word (fill_word),
      .i_wr_data (line_wdata),
      .o_hit     (way_hit[w]),
      .o_rdata   (way_rdata[w]),
      .o_valid   (way_valid[w])
    );
  end

  cache_hit_resolve u_resolve (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_addr         (req_addr),
    .i_way_hit      (way_hit),
    .i_way_rdata    (way_rdata),
    .i_way_valid    (way_valid),
    .i_mask         (i_req_mask),
    .i_set_mru_en   (set_mru_en),
    .i_set_mru      (set_mru),
    .o_hit          (hit),
    .o_hit_way      (hit_way),
    .o_hit_rdata    (hit_rdata),
    .o_rdata_masked (o_res_rdata),
    .o_victim       (victim)
  );

endmodule

`default_nettype wire

/* verilog/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
  import cache_pkg::*;
(
  input  wire                      i_clk,
  input  wire                      i_rst,
  // CPU request, held stable while o_busy is high
  input  wire                      i_req_ren,
  input  wire                      i_req_wen,
  input  wire cache_addr_t         i_req_addr,
  input  wire [3:0]                i_req_mask,
  input  wire [31:0]               i_req_wdata,
  // lookup result from the resolver
  input  wire                      i_hit,
  input  wire                      i_hit_way,
  input  wire [31:0]               i_hit_rdata,
  input  wire                      i_victim,
  // word memory
  input  wire                      i_mem_ready,
  input  wire                      i_mem_valid,
  input  wire [31:0]               i_mem_rdata,
  output logic                     o_busy,
  output logic [31:0]              o_mem_addr,
  output logic                     o_mem_ren,
  output logic                     o_mem_wen,
  output logic [31:0]              o_mem_wdata,
  // write port of the ways
  output logic [num_ways-1:0]      o_way_wr,
  output logic [num_ways-1:0]      o_tag_wr,
  output logic [word_sel_bits-1:0] o_fill_word,
  output logic [31:0]              o_line_wdata,
  // MRU update in the resolver
  output logic                     o_set_mru_en,
  output logic                     o_set_mru
);

  ctrl_state_t              state;
  // request kind and victim, captured when leaving idle
  logic                     is_write;
  logic                     victim_q;
  // word index of the next fill read and its outstanding flag
  logic [word_sel_bits-1:0] fill_cnt;
  logic                     rd_pending;
  logic [31:0]              byte_en;
  logic [31:0]              merged;
  logic                     rd_issue;
  logic                     wr_issue;
  logic                     fill_done;

  // expand the byte mask to bit lanes for the store merge
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      byte_en[8*b +: 8] = {8{i_req_mask[b]}};
    end
  end

  // masked bytes come from the store, the rest from the cached word
  assign merged = (i_req_wdata & byte_en) | (i_hit_rdata & ~byte_en);

  // a new line read goes out once the previous word is back and memory is ready
  assign rd_issue  = (state == st_fill) && !i_mem_valid && !rd_pending && i_mem_ready;
  // the store goes out once, the cycle after it o_mem_wen is high
  assign wr_issue  = (state == st_write) && i_mem_ready && !o_mem_wen;
  // the fourth returned word closes the fill
  assign fill_done = (state == st_fill) && i_mem_valid && (&fill_cnt);

  // stall on a read miss or any store, and for as long as a request runs
  always_comb begin
    case (state)
      st_idle: o_busy = i_req_wen || (i_req_ren && !i_hit);
      default: o_busy = 1'b1;
    endcase
  end

  // fill words land in the victim, the merged store word in the hit way
  always_comb begin
    o_way_wr = '0;
    o_tag_wr = '0;
    if (state == st_fill && i_mem_valid) begin
      o_way_wr[victim_q] = 1'b1;
      o_tag_wr[victim_q] = fill_done;
    end else if (wr_issue) begin
      o_way_wr[i_hit_way] = 1'b1;
    end
  end

  assign o_fill_word  = (state == st_fill) ? fill_cnt : i_req_addr.f.word;
  assign o_line_wdata = (state == st_fill) ? i_mem_rdata : merged;

  // the way just filled or just written becomes MRU
  assign o_set_mru_en = fill_done || wr_issue;
  assign o_set_mru    = (state == st_fill) ? victim_q : i_hit_way;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= st_idle;
      is_write   <= 1'b0;
      victim_q   <= 1'b0;
      fill_cnt   <= '0;
      rd_pending <= 1'b0;
      o_mem_ren  <= 1'b0;
      o_mem_wen  <= 1'b0;
    end else begin
      // memory strobes are single-cycle pulses
      o_mem_ren <= 1'b0;
      o_mem_wen <= 1'b0;
      case (state)
        st_idle: begin
          is_write   <= i_req_wen;
          victim_q   <= i_victim;
          fill_cnt   <= '0;
          rd_pending <= 1'b0;
          // a store that hits skips the fill
          if (o_busy) begin
            state <= (i_req_wen && i_hit) ? st_write : st_fill;
          end
        end
        st_fill: begin
          if (i_mem_valid) begin
            rd_pending <= 1'b0;
            fill_cnt   <= fill_cnt + 1'b1;
            if (fill_done) begin
              state <= is_write ? st_write : st_idle;
            end
          end else if (rd_issue) begin
            rd_pending <= 1'b1;
            o_mem_ren  <= 1'b1;
          end
        end
        st_write: begin
          if (o_mem_wen) begin
            state <= st_idle;
          end else if (wr_issue) begin
            o_mem_wen <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // fill reads walk the line from word 0, stores go to the aligned word
  always_ff @(posedge i_clk) begin
    if (rd_issue) begin
      o_mem_addr <= {i_req_addr.f.tag, i_req_addr.f.index, fill_cnt, 2'b00};
    end else if (wr_issue) begin
      o_mem_addr  <= {i_req_addr.raw[31:2], 2'b00};
      o_mem_wdata <= merged;
    end
  end

  // the CPU never asks for a load and a store at once
  req_exclusive: assert property (
    @(posedge i_clk) disable iff (i_rst)
    !(i_req_ren && i_req_wen)
  );

  // line reads only appear while a fill runs
  ren_in_fill: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_mem_ren |-> (state == st_fill)
  );

endmodule

`default_nettype wire

/* verilog/cache_hit_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_hit_resolve
  import cache_pkg::*;
(
  input  wire                           i_clk,
  input  wire                           i_rst,
  input  wire cache_addr_t              i_addr,
  input  wire [num_ways-1:0]            i_way_hit,
  input  wire [num_ways-1:0][31:0]      i_way_rdata,
  input  wire [num_ways-1:0]            i_way_valid,
  input  wire [3:0]                     i_mask,
  // MRU update for the request set, from the controller
  input  wire                           i_set_mru_en,
  input  wire                           i_set_mru,
  output logic                          o_hit,
  output logic                          o_hit_way,
  // unmasked word of the hitting way, for the store merge
  output logic [31:0]                   o_hit_rdata,
  output logic [31:0]                   o_rdata_masked,
  output logic                          o_victim
);

  // one bit per set naming the most recently used way
  logic [num_sets-1:0] mru;

  assign o_hit = |i_way_hit;

  // at most one way hits, so the last match in the loop is the only one
  always_comb begin
    o_hit_rdata = '0;
    o_hit_way   = 1'b0;
    for (int w = 0; w < num_ways; w++) begin
      if (i_way_hit[w]) begin
        o_hit_rdata = i_way_rdata[w];
        o_hit_way   = 1'(w);
      end
    end
  end

  // bytes outside the load mask read as zero
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      o_rdata_masked[8*b +: 8] = i_mask[b] ? o_hit_rdata[8*b +: 8] : 8'h00;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mru <= '0;
    end else if (i_set_mru_en) begin
      mru[i_addr.f.index] <= i_set_mru;
    end
  end

  // empty ways are filled first, lowest first, then the way not used last
  always_comb begin
    if (!i_way_valid[0]) begin
      o_victim = 1'b0;
    end else if (!i_way_valid[1]) begin
      o_victim = 1'b1;
    end else begin
      o_victim = !mru[i_addr.f.index];
    end
  end

  // a tag never lives in both ways of one set
  single_hit: assert property (
    @(posedge i_clk) disable iff (i_rst)
    $onehot0(i_way_hit)
  );

endmodule

`default_nettype wire

/* verilog/cache_way.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_way
  import cache_pkg::*;
(
  input  wire                     i_clk,
  input  wire                     i_rst,
  // request address, held by the CPU for the whole request
  input  wire cache_addr_t        i_addr,
  // word write into the selected set
  input  wire                     i_wr,
  // tag write, which also marks the line valid
  input  wire                     i_tag_wr,
  // word index of the write, fill counter or request word
  input  wire [word_sel_bits-1:0] i_wr_word,
  input  wire [31:0]              i_wr_data,
  output logic                    o_hit,
  output logic [31:0]             o_rdata,
  // valid bit of the addressed set, used for the victim choice
  output logic                    o_valid
);

  // one valid bit per set, the only state cleared at reset
  logic [num_sets-1:0] valid;
  // tag and data storage
  logic [tag_bits-1:0] tags  [num_sets];
  logic [31:0]         words [num_sets][words_per_line];

  // a line turns valid together with its tag on the last fill word
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid <= '0;
    end else if (i_tag_wr) begin
      valid[i_addr.f.index] <= 1'b1;
    end
  end

  // the arrays need no reset because a line only hits once it is valid
  always_ff @(posedge i_clk) begin
    if (i_tag_wr) begin
      tags[i_addr.f.index] <= i_addr.f.tag;
    end
    if (i_wr) begin
      words[i_addr.f.index][i_wr_word] <= i_wr_data;
    end
  end

  // lookup is purely combinational on the request address
  assign o_valid = valid[i_addr.f.index];
  assign o_hit   = o_valid && (tags[i_addr.f.index] == i_addr.f.tag);

  // the word at the request offset, whether or not this way hits
  assign o_rdata = words[i_addr.f.index][i_addr.f.word];

  // the controller writes the tag only together with the fourth fill word
  tag_with_word: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_tag_wr |-> i_wr
  );

endmodule

`default_nettype wire

/* verilog/cache_pkg.sv */
`default_nettype none

package cache_pkg;

  // byte offset inside a 16-byte line
  localparam int offset_bits = 4;
  // set index, 32 sets
  localparam int index_bits = 5;
  localparam int num_sets = 32;
  // two-way set associative
  localparam int num_ways = 2;
  // whatever is left of the address above index and offset
  localparam int tag_bits = 32 - index_bits - offset_bits;
  // a line holds four 32-bit words
  localparam int words_per_line = 4;
  localparam int word_sel_bits = 2;

  // the request address is read as a plain word on the memory side
  // and as tag, set and word fields for the lookup
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [tag_bits-1:0]      tag;
      logic [index_bits-1:0]    index;
      logic [word_sel_bits-1:0] word;
      logic [1:0]               byte_sel;
    } f;
  } cache_addr_t;

  // controller states: waiting for a request, filling a line, write-through
  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_fill  = 2'd1,
    st_write = 2'd2
  } ctrl_state_t;

endpackage

`default_nettype wire
